// ==== dupMacros.svh ====
// DUP11 receiver register map
`ifndef DUP_MACROS_SVH
`define DUP_MACROS_SVH

// Sync character the receiver hunts for
`define dupSYNC_CHAR      8'h16

// Register word offsets on the bus
`define dupADDR_RXCSR     3'd0
`define dupADDR_RXDBUF    3'd2

// RXCSR bit positions
`define dupRXCSR_DSCA     15
`define dupRXCSR_RI       14
`define dupRXCSR_CTS      13
`define dupRXCSR_DCD      12
`define dupRXCSR_RXACT    11
`define dupRXCSR_SECRX    10
`define dupRXCSR_DSR      9
`define dupRXCSR_STRSYN   8
`define dupRXCSR_RXDONE   7
`define dupRXCSR_RXIE     6
`define dupRXCSR_DSCIE    5
`define dupRXCSR_RXEN     4
`define dupRXCSR_SECTX    3
`define dupRXCSR_RTS      2
`define dupRXCSR_DTR      1
`define dupRXCSR_DSCB     0

// RXDBUF fields
`define dupRXDBUF_ERR     15
`define dupRXDBUF_OVRUN   14
`define dupRXDBUF_DATA    7:0

`endif

// ==== dupPkg.sv ====
// DUP11 receiver types
package dupPkg;

   ////////////////////
   // Receive shifter state
   ////////////////////

   typedef enum logic [1:0] {
      // Receiver disabled
      RX_IDLE = 2'd0,
      // Searching the bit stream for sync
      RX_HUNT = 2'd1,
      // Locked on and framing characters
      RX_SYNC = 2'd2
   } dupRxState_t;

   ////////////////////
   // Bus register select
   ////////////////////

   typedef enum logic {
      REG_RXCSR  = 1'b0,
      REG_RXDBUF = 1'b1
   } dupRegSel_t;

endpackage

// ==== dupRxCharIf.sv ====
// DUP11 receive character link
`timescale 1ns/1ps

interface dupRxCharIf;

   // Received character
   logic [7:0] charData;
   // One cycle strobe per character
   logic       charValid;
   // Character matches the sync pattern
   logic       charIsSync;
   // Sync that ended the hunt
   logic       charFirst;

   // Upstream stage drives the link
   modport source (output charData, charValid, charIsSync, charFirst);
   // Downstream stage reads it
   modport sink (input charData, charValid, charIsSync, charFirst);

endinterface

// ==== dupRxShifter.sv ====
// DUP11 receive shifter
`timescale 1ns/1ps
`include "dupMacros.svh"

module dupRxShifter (
   input  logic       clk,
   input  logic       rst,
   input  logic       init,
   input  logic       rxEn,
   input  logic       rxClkEn,
   input  logic       rxSerial,
   output logic       rxActive,
   dupRxCharIf.source charOut
);

   import dupPkg::*;

   dupRxState_t state;
   logic [7:0]  shiftReg;
   logic [7:0]  shiftNext;
   logic [2:0]  bitCnt;
   logic        charPend;
   logic        pendFirst;

   // Line is LSB first so each new bit enters at the top
   assign shiftNext = {rxSerial, shiftReg[7:1]};

   ////////////////////
   // Hunt and framing FSM
   ////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         state     <= RX_IDLE;
         shiftReg  <= '0;
         bitCnt    <= '0;
         charPend  <= 1'b0;
         pendFirst <= 1'b0;
      end
      else if (init || !rxEn)
      begin
         // Drop lock and forget any partial character
         state     <= RX_IDLE;
         shiftReg  <= '0;
         bitCnt    <= '0;
         charPend  <= 1'b0;
         pendFirst <= 1'b0;
      end
      else
      begin
         // Pending flags live for one cycle only
         charPend  <= 1'b0;
         pendFirst <= 1'b0;
         case (state)
            RX_IDLE:
            begin
               state <= RX_HUNT;
            end
            RX_HUNT:
            begin
               // Compare the last eight bits after every bit
               if (rxClkEn)
               begin
                  shiftReg <= shiftNext;
                  if (shiftNext == `dupSYNC_CHAR)
                  begin
                     state     <= RX_SYNC;
                     bitCnt    <= '0;
                     charPend  <= 1'b1;
                     pendFirst <= 1'b1;
                  end
               end
            end
            RX_SYNC:
            begin
               // Eighth bit completes a character
               if (rxClkEn)
               begin
                  shiftReg <= shiftNext;
                  bitCnt   <= bitCnt + 3'd1;
                  if (bitCnt == 3'd7)
                  begin
                     charPend <= 1'b1;
                  end
               end
            end
            default:
            begin
               state <= RX_IDLE;
            end
         endcase
      end
   end

   ////////////////////
   // Character output register
   ////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         charOut.charValid  <= 1'b0;
         charOut.charIsSync <= 1'b0;
         charOut.charFirst  <= 1'b0;
      end
      else if (init)
      begin
         charOut.charValid  <= 1'b0;
         charOut.charIsSync <= 1'b0;
         charOut.charFirst  <= 1'b0;
      end
      else
      begin
         charOut.charValid  <= charPend;
         charOut.charIsSync <= (shiftReg == `dupSYNC_CHAR);
         charOut.charFirst  <= pendFirst;
      end
   end

   // Data only moves with a framed character
   always_ff @(posedge clk)
   begin
      if (charPend)
      begin
         charOut.charData <= shiftReg;
      end
   end

   // Active once sync has been found
   assign rxActive = (state == RX_SYNC);

endmodule

// ==== dupRxSyncStrip.sv ====
// DUP11 sync stripper
`timescale 1ns/1ps

module dupRxSyncStrip (
   input  logic       clk,
   input  logic       rst,
   input  logic       init,
   input  logic       strSyn,
   dupRxCharIf.sink   charIn,
   dupRxCharIf.source charOut
);

   logic dropChar;

   // Fill syncs are dropped but the sync that ended the hunt marks lock
   assign dropChar = strSyn && charIn.charIsSync && !charIn.charFirst;

   ////////////////////
   // Stage register
   ////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         charOut.charValid  <= 1'b0;
         charOut.charIsSync <= 1'b0;
         charOut.charFirst  <= 1'b0;
      end
      else if (init)
      begin
         charOut.charValid  <= 1'b0;
         charOut.charIsSync <= 1'b0;
         charOut.charFirst  <= 1'b0;
      end
      else
      begin
         charOut.charValid  <= charIn.charValid && !dropChar;
         charOut.charIsSync <= charIn.charIsSync;
         charOut.charFirst  <= charIn.charFirst;
      end
   end

   // Character bits pass unchanged
   always_ff @(posedge clk)
   begin
      if (charIn.charValid)
      begin
         charOut.charData <= charIn.charData;
      end
   end

endmodule

// ==== dupRxBuffer.sv ====
// DUP11 receive data buffer
`timescale 1ns/1ps
`include "dupMacros.svh"

module dupRxBuffer (
   input  logic        clk,
   input  logic        rst,
   input  logic        init,
   input  logic        rdBuf,
   dupRxCharIf.sink    charIn,
   output logic        rxDone,
   output logic [15:0] rxdbuf
);

   logic [7:0] dataReg;
   logic       ovrun;
   logic       errSum;
   logic       overrunNow;

   // Old character never read before the new one lands
   assign overrunNow = rxDone && !rdBuf;

   ////////////////////
   // Holding register and flags
   ////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         dataReg <= '0;
         rxDone  <= 1'b0;
         ovrun   <= 1'b0;
         errSum  <= 1'b0;
      end
      else if (init)
      begin
         rxDone <= 1'b0;
         ovrun  <= 1'b0;
         errSum <= 1'b0;
      end
      else if (charIn.charValid)
      begin
         // A clean load also clears the error bits
         dataReg <= charIn.charData;
         rxDone  <= 1'b1;
         ovrun   <= overrunNow;
         errSum  <= overrunNow;
      end
      else if (rdBuf)
      begin
         // Read returns the old value and clears done here
         rxDone <= 1'b0;
      end
   end

   ////////////////////
   // RXDBUF word
   ////////////////////

   always_comb
   begin
      rxdbuf                    = '0;
      rxdbuf[`dupRXDBUF_ERR]    = errSum;
      rxdbuf[`dupRXDBUF_OVRUN]  = ovrun;
      rxdbuf[`dupRXDBUF_DATA]   = dataReg;
   end

endmodule

// ==== dupRxCsr.sv ====
// DUP11 receiver control and status
`timescale 1ns/1ps
`include "dupMacros.svh"

module dupRxCsr (
   input  logic        clk,
   input  logic        rst,
   input  logic        init,
   input  logic        csrRead,
   input  logic        csrWrite,
   input  logic        loByte,
   input  logic        hiByte,
   input  logic [15:0] dataIn,
   input  logic        w3,
   input  logic        w5,
   input  logic        w6,
   input  logic        ri,
   input  logic        cts,
   input  logic        dcd,
   input  logic        dsr,
   input  logic        rxActive,
   input  logic        rxDone,
   output logic        rts,
   output logic        dtr,
   output logic        rxEn,
   output logic        strSyn,
   output logic        rxIntr,
   output logic [15:0] rxcsr
);

   // Positions of the watched lines in the line vectors
   localparam int lnRi    = 0;
   localparam int lnCts   = 1;
   localparam int lnDcd   = 2;
   localparam int lnDsr   = 3;
   localparam int lnSecRx = 4;

   logic       secTx;
   logic       secRx;
   logic       rxIe;
   logic       dscIe;
   logic       dsca;
   logic       dscb;
   logic [4:0] lineNow;
   logic [4:0] lineQ;
   logic [4:0] lineLast;
   logic [4:0] lineChg;
   logic [1:0] readHist;
   logic       flagClr;
   logic       loWrite;
   logic       hiWrite;
   logic       dscaSet;
   logic       dscbSet;

   assign loWrite = csrWrite && loByte;
   assign hiWrite = csrWrite && hiByte;

   // Secondary data loops straight back
   assign secRx = secTx;

   ////////////////////
   // Modem line watch
   ////////////////////

   assign lineNow = {secRx, dsr, dcd, cts, ri};

   // First stage samples the lines and the second keeps the old value
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         lineQ    <= '0;
         lineLast <= '0;
      end
      else
      begin
         lineQ    <= lineNow;
         lineLast <= lineQ;
      end
   end

   assign lineChg = lineQ ^ lineLast;

   // RI and CTS always count toward DSCA
   assign dscaSet = lineChg[lnRi] || lineChg[lnCts] ||
                    (w5 && (lineChg[lnDcd] || lineChg[lnDsr] || lineChg[lnSecRx]));
   assign dscbSet = w6 && (lineChg[lnDcd] || lineChg[lnDsr] || lineChg[lnSecRx]);

   // Change flags clear once the RXCSR read has ended
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         readHist <= '0;
      end
      else
      begin
         readHist <= {readHist[0], csrRead};
      end
   end

   assign flagClr = readHist[1] && !readHist[0];

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         dsca <= 1'b0;
         dscb <= 1'b0;
      end
      else if (init || flagClr)
      begin
         dsca <= 1'b0;
         dscb <= 1'b0;
      end
      else
      begin
         // Flags stick until cleared
         if (dscaSet)
         begin
            dsca <= 1'b1;
         end
         if (dscbSet)
         begin
            dscb <= 1'b1;
         end
      end
   end

   ////////////////////
   // Writable control bits
   ////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         strSyn <= 1'b0;
         rxIe   <= 1'b0;
         dscIe  <= 1'b0;
         rxEn   <= 1'b0;
      end
      else if (init)
      begin
         strSyn <= 1'b0;
         rxIe   <= 1'b0;
         dscIe  <= 1'b0;
         rxEn   <= 1'b0;
      end
      else
      begin
         if (hiWrite)
         begin
            strSyn <= dataIn[`dupRXCSR_STRSYN];
         end
         if (loWrite)
         begin
            rxIe  <= dataIn[`dupRXCSR_RXIE];
            dscIe <= dataIn[`dupRXCSR_DSCIE];
            rxEn  <= dataIn[`dupRXCSR_RXEN];
         end
      end
   end

   // Modem outputs survive init unless W3 is fitted
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         secTx <= 1'b0;
         rts   <= 1'b0;
         dtr   <= 1'b0;
      end
      else if (init && w3)
      begin
         secTx <= 1'b0;
         rts   <= 1'b0;
         dtr   <= 1'b0;
      end
      else if (loWrite)
      begin
         secTx <= dataIn[`dupRXCSR_SECTX];
         rts   <= dataIn[`dupRXCSR_RTS];
         dtr   <= dataIn[`dupRXCSR_DTR];
      end
   end

   ////////////////////
   // Interrupt and RXCSR word
   ////////////////////

   assign rxIntr = (rxIe && rxDone) || (dscIe && (dsca || dscb));

   always_comb
   begin
      rxcsr                    = '0;
      rxcsr[`dupRXCSR_DSCA]    = dsca;
      rxcsr[`dupRXCSR_RI]      = lineQ[lnRi];
      rxcsr[`dupRXCSR_CTS]     = lineQ[lnCts];
      rxcsr[`dupRXCSR_DCD]     = lineQ[lnDcd];
      rxcsr[`dupRXCSR_RXACT]   = rxActive;
      rxcsr[`dupRXCSR_SECRX]   = secRx;
      rxcsr[`dupRXCSR_DSR]     = lineQ[lnDsr];
      rxcsr[`dupRXCSR_STRSYN]  = strSyn;
      rxcsr[`dupRXCSR_RXDONE]  = rxDone;
      rxcsr[`dupRXCSR_RXIE]    = rxIe;
      rxcsr[`dupRXCSR_DSCIE]   = dscIe;
      rxcsr[`dupRXCSR_RXEN]    = rxEn;
      rxcsr[`dupRXCSR_SECTX]   = secTx;
      rxcsr[`dupRXCSR_RTS]     = rts;
      rxcsr[`dupRXCSR_DTR]     = dtr;
      rxcsr[`dupRXCSR_DSCB]    = dscb;
   end

endmodule

// ==== dupRxTop.sv ====
// DUP11 receiver top level
`timescale 1ns/1ps
`include "dupMacros.svh"

module dupRxTop (
   input  logic        clk,
   input  logic        rst,
   input  logic        init,
   input  logic [2:0]  busAddr,
   input  logic        busRead,
   input  logic        busWrite,
   input  logic        busLoByte,
   input  logic        busHiByte,
   input  logic [15:0] busDataIn,
   input  logic        w3,
   input  logic        w5,
   input  logic        w6,
   input  logic        ri,
   input  logic        cts,
   input  logic        dcd,
   input  logic        dsr,
   input  logic        rxClkEn,
   input  logic        rxSerial,
   output logic [15:0] busDataOut,
   output logic        rts,
   output logic        dtr,
   output logic        rxIntr
);

   import dupPkg::*;

   dupRegSel_t  regSel;
   logic        regHit;
   logic        csrRead;
   logic        csrWrite;
   logic        bufRead;
   logic        rxEn;
   logic        strSyn;
   logic        rxActive;
   logic        rxDone;
   logic [15:0] rxcsr;
   logic [15:0] rxdbuf;

   // Links between the pipeline stages
   dupRxCharIf shifterToStrip ();
   dupRxCharIf stripToBuffer ();

   ////////////////////
   // Bus register decode
   ////////////////////

   always_comb
   begin
      regHit = 1'b1;
      regSel = REG_RXCSR;
      case (busAddr)
         `dupADDR_RXCSR:  regSel = REG_RXCSR;
         `dupADDR_RXDBUF: regSel = REG_RXDBUF;
         // Transmit side registers are not here
         default:         regHit = 1'b0;
      endcase
   end

   assign csrRead  = busRead && regHit && (regSel == REG_RXCSR);
   assign csrWrite = busWrite && regHit && (regSel == REG_RXCSR);
   // RXDBUF is read only
   assign bufRead  = busRead && regHit && (regSel == REG_RXDBUF);

   // Reads are combinational and show the value before any clear
   always_comb
   begin
      busDataOut = '0;
      if (busRead && regHit)
      begin
         busDataOut = (regSel == REG_RXDBUF) ? rxdbuf : rxcsr;
      end
   end

   ////////////////////
   // Receive pipeline
   ////////////////////

   dupRxShifter i_shifter (
      .clk      (clk),
      .rst      (rst),
      .init     (init),
      .rxEn     (rxEn),
      .rxClkEn  (rxClkEn),
      .rxSerial (rxSerial),
      .rxActive (rxActive),
      .charOut  (shifterToStrip)
   );

   dupRxSyncStrip i_syncStrip (
      .clk     (clk),
      .rst     (rst),
      .init    (init),
      .strSyn  (strSyn),
      .charIn  (shifterToStrip),
      .charOut (stripToBuffer)
   );

   dupRxBuffer i_buffer (
      .clk    (clk),
      .rst    (rst),
      .init   (init),
      .rdBuf  (bufRead),
      .charIn (stripToBuffer),
      .rxDone (rxDone),
      .rxdbuf (rxdbuf)
   );

   // Control and status beside the pipeline
   dupRxCsr i_csr (
      .clk      (clk),
      .rst      (rst),
      .init     (init),
      .csrRead  (csrRead),
      .csrWrite (csrWrite),
      .loByte   (busLoByte),
      .hiByte   (busHiByte),
      .dataIn   (busDataIn),
      .w3       (w3),
      .w5       (w5),
      .w6       (w6),
      .ri       (ri),
      .cts      (cts),
      .dcd      (dcd),
      .dsr      (dsr),
      .rxActive (rxActive),
      .rxDone   (rxDone),
      .rts      (rts),
      .dtr      (dtr),
      .rxEn     (rxEn),
      .strSyn   (strSyn),
      .rxIntr   (rxIntr),
      .rxcsr    (rxcsr)
   );

endmodule

// ==== tbDupRx.sv ====
// DUP11 receiver testbench
`timescale 1ns/1ps
`include "dupMacros.svh"

module tbDupRx;

   localparam int numData    = 12;
   localparam int charCycles = 16;
   // Rough length of all tests in clock cycles
   localparam int testCycles = 10 + 80 + 300 + 2 * ((numData + 4) * charCycles + 120) + 150;
   localparam int timeoutCycles = 2 * testCycles + 1000;

   logic        clk;
   logic        rst;
   logic        init;
   logic [2:0]  busAddr;
   logic        busRead;
   logic        busWrite;
   logic        busLoByte;
   logic        busHiByte;
   logic [15:0] busDataIn;
   logic        w3;
   logic        w5;
   logic        w6;
   logic        ri;
   logic        cts;
   logic        dcd;
   logic        dsr;
   logic        rxClkEn;
   logic        rxSerial;
   logic [15:0] busDataOut;
   logic        rts;
   logic        dtr;
   logic        rxIntr;

   integer      seed;
   int          errCount;
   int          checkCount;
   int          testErrBase;
   int          cycleCount;
   logic [15:0] csr;
   logic [15:0] dbuf;
   logic [7:0]  data;
   logic [7:0]  txQ[$];
   logic [7:0]  expQ[$];

   dupRxTop i_dut (
      .clk        (clk),
      .rst        (rst),
      .init       (init),
      .busAddr    (busAddr),
      .busRead    (busRead),
      .busWrite   (busWrite),
      .busLoByte  (busLoByte),
      .busHiByte  (busHiByte),
      .busDataIn  (busDataIn),
      .w3         (w3),
      .w5         (w5),
      .w6         (w6),
      .ri         (ri),
      .cts        (cts),
      .dcd        (dcd),
      .dsr        (dsr),
      .rxClkEn    (rxClkEn),
      .rxSerial   (rxSerial),
      .busDataOut (busDataOut),
      .rts        (rts),
      .dtr        (dtr),
      .rxIntr     (rxIntr)
   );

   // 4 ns clock
   always #2 clk = ~clk;

   ////////////////////
   // Checks
   ////////////////////

   task automatic checkWord(input string name, input logic [15:0] got, input logic [15:0] exp);
      checkCount++;
      assert (got === exp)
      else
      begin
         $display("error %s got %h expected %h", name, got, exp);
         errCount++;
      end
   endtask

   task automatic checkBit(input string name, input logic got, input logic exp);
      checkCount++;
      assert (got === exp)
      else
      begin
         $display("error %s got %h expected %h", name, got, exp);
         errCount++;
      end
   endtask

   task automatic checkTrue(input logic cond, input string what);
      checkCount++;
      assert (cond)
      else
      begin
         $display("%s", what);
         errCount++;
      end
   endtask

   task automatic reportTest(input string name);
      if (errCount == testErrBase)
         $display("test %s: ok", name);
      else
         $display("test %s: %0d errors", name, errCount - testErrBase);
      testErrBase = errCount;
   endtask

   ////////////////////
   // Bus and line drivers
   ////////////////////

   task automatic waitCycles(input int n);
      repeat (n) @(posedge clk);
   endtask

   // Write lands at the second edge
   task automatic writeReg(input logic [2:0] addr, input logic [15:0] value,
                           input logic lo, input logic hi);
      @(posedge clk);
      busAddr   <= addr;
      busDataIn <= value;
      busLoByte <= lo;
      busHiByte <= hi;
      busWrite  <= 1'b1;
      @(posedge clk);
      busWrite  <= 1'b0;
      busLoByte <= 1'b0;
      busHiByte <= 1'b0;
   endtask

   // Sampled mid cycle while busRead is high
   task automatic readReg(input logic [2:0] addr, output logic [15:0] value);
      @(posedge clk);
      busAddr <= addr;
      busRead <= 1'b1;
      @(negedge clk);
      value = busDataOut;
      @(posedge clk);
      busRead <= 1'b0;
   endtask

   task automatic pulseInit(input logic jumper);
      @(posedge clk);
      init <= 1'b1;
      w3   <= jumper;
      @(posedge clk);
      init <= 1'b0;
      w3   <= 1'b0;
   endtask

   // LSB first with a bit strobe every other cycle
   task automatic sendByte(input logic [7:0] b);
      logic [7:0] sh;
      sh = b;
      repeat (8)
      begin
         @(posedge clk);
         rxSerial <= sh[0];
         rxClkEn  <= 1'b1;
         @(posedge clk);
         rxClkEn  <= 1'b0;
         sh = sh >> 1;
      end
   endtask

   // Poll RXCSR until a character is reported
   task automatic waitRxDone(output logic [15:0] value);
      int polls;
      polls = 0;
      value = '0;
      while (!value[`dupRXCSR_RXDONE] && polls < 40)
      begin
         readReg(`dupADDR_RXCSR, value);
         polls++;
      end
      checkTrue(value[`dupRXCSR_RXDONE], "no received character showed up in RXDONE");
   endtask

   // Toggle one modem line, then check both change flags and their clear
   task automatic toggleModemLine(input int which, input logic expA, input logic expB);
      logic [15:0] value;
      @(posedge clk);
      case (which)
         0: ri <= !ri;
         1: cts <= !cts;
         default: dcd <= !dcd;
      endcase
      waitCycles(3);
      readReg(`dupADDR_RXCSR, value);
      checkBit("DSCA", value[`dupRXCSR_DSCA], expA);
      checkBit("DSCB", value[`dupRXCSR_DSCB], expB);
      waitCycles(4);
      readReg(`dupADDR_RXCSR, value);
      checkBit("DSCA after read", value[`dupRXCSR_DSCA], 1'b0);
      checkBit("DSCB after read", value[`dupRXCSR_DSCB], 1'b0);
      waitCycles(4);
   endtask

   ////////////////////
   // Receive stream
   ////////////////////

   task automatic receiveStream(input logic strip);
      logic [15:0] ctrl;
      logic [15:0] value;
      logic [15:0] word;
      logic [7:0]  b;
      int          k;
      int          n;
      int          m;
      txQ.delete();
      expQ.delete();
      txQ.push_back(`dupSYNC_CHAR);
      txQ.push_back(`dupSYNC_CHAR);
      for (k = 0; k < numData; k++)
      begin
         b = 8'($random(seed));
         // Data bytes never look like sync
         if (b == `dupSYNC_CHAR)
            b = ~b;
         txQ.push_back(b);
         // Fill sync in mid message
         if (k == numData / 2)
            txQ.push_back(`dupSYNC_CHAR);
      end
      // Sync that ends the hunt always reaches the buffer
      expQ.push_back(`dupSYNC_CHAR);
      for (k = 1; k < txQ.size(); k++)
      begin
         if (!(strip && txQ[k] == `dupSYNC_CHAR))
            expQ.push_back(txQ[k]);
      end
      // Restart the receiver from the hunt
      ctrl = '0;
      ctrl[`dupRXCSR_RXEN] = 1'b1;
      ctrl[`dupRXCSR_STRSYN] = strip;
      writeReg(`dupADDR_RXCSR, 16'h0000, 1'b1, 1'b1);
      writeReg(`dupADDR_RXCSR, ctrl, 1'b1, 1'b1);
      fork
         begin
            for (n = 0; n < txQ.size(); n++)
               sendByte(txQ[n]);
         end
         begin
            for (m = 0; m < expQ.size(); m++)
            begin
               waitRxDone(value);
               checkBit("RXACT", value[`dupRXCSR_RXACT], 1'b1);
               readReg(`dupADDR_RXDBUF, word);
               checkWord("RXDBUF", word, {8'h00, expQ[m]});
               readReg(`dupADDR_RXCSR, value);
               checkBit("RXDONE after RXDBUF read", value[`dupRXCSR_RXDONE], 1'b0);
            end
         end
      join
      // Nothing more may turn up
      waitCycles(2 * charCycles);
      readReg(`dupADDR_RXCSR, value);
      checkBit("RXDONE at end of stream", value[`dupRXCSR_RXDONE], 1'b0);
   endtask

   ////////////////////
   // Test sequence
   ////////////////////

   initial
   begin
      clk = 1'b0;
      rst = 1'b1;
      init = 1'b0;
      busAddr = '0;
      busRead = 1'b0;
      busWrite = 1'b0;
      busLoByte = 1'b0;
      busHiByte = 1'b0;
      busDataIn = '0;
      w3 = 1'b0;
      w5 = 1'b0;
      w6 = 1'b0;
      ri = 1'b0;
      cts = 1'b0;
      dcd = 1'b0;
      dsr = 1'b0;
      rxClkEn = 1'b0;
      rxSerial = 1'b0;
      seed = 32'h739b_8128;
      errCount = 0;
      checkCount = 0;
      testErrBase = 0;
      repeat (10) @(posedge clk);
      rst <= 1'b0;
      waitCycles(2);

      // Reset values, byte lanes and init
      readReg(`dupADDR_RXCSR, csr);
      checkWord("RXCSR", csr, 16'h0000);
      checkBit("rts", rts, 1'b0);
      checkBit("dtr", dtr, 1'b0);
      checkBit("rxIntr", rxIntr, 1'b0);
      // High byte data must be ignored here
      writeReg(`dupADDR_RXCSR, 16'h017e, 1'b1, 1'b0);
      readReg(`dupADDR_RXCSR, csr);
      checkWord("RXCSR", csr, 16'h007e | (16'h1 << `dupRXCSR_SECRX));
      checkBit("rts", rts, 1'b1);
      checkBit("dtr", dtr, 1'b1);
      // Low byte data must be ignored here
      writeReg(`dupADDR_RXCSR, 16'h0181, 1'b0, 1'b1);
      readReg(`dupADDR_RXCSR, csr);
      checkWord("RXCSR", csr, 16'h057e);
      pulseInit(1'b0);
      readReg(`dupADDR_RXCSR, csr);
      checkWord("RXCSR", csr, 16'h040e);
      pulseInit(1'b1);
      readReg(`dupADDR_RXCSR, csr);
      checkWord("RXCSR", csr, 16'h0000);
      checkBit("rts", rts, 1'b0);
      checkBit("dtr", dtr, 1'b0);
      reportTest("1 reset and writes");

      // Modem change flags
      toggleModemLine(0, 1'b1, 1'b0);
      toggleModemLine(1, 1'b1, 1'b0);
      toggleModemLine(2, 1'b0, 1'b0);
      @(posedge clk);
      w5 <= 1'b1;
      toggleModemLine(2, 1'b1, 1'b0);
      @(posedge clk);
      w5 <= 1'b0;
      w6 <= 1'b1;
      toggleModemLine(2, 1'b0, 1'b1);
      @(posedge clk);
      w6 <= 1'b0;
      // DSCA pending with DSCIE off
      @(posedge clk);
      ri <= !ri;
      waitCycles(3);
      @(negedge clk);
      checkBit("rxIntr", rxIntr, 1'b0);
      writeReg(`dupADDR_RXCSR, 16'h0020, 1'b1, 1'b0);
      @(negedge clk);
      checkBit("rxIntr", rxIntr, 1'b1);
      readReg(`dupADDR_RXCSR, csr);
      waitCycles(4);
      @(negedge clk);
      checkBit("rxIntr", rxIntr, 1'b0);
      writeReg(`dupADDR_RXCSR, 16'h0000, 1'b1, 1'b0);
      reportTest("2 modem change flags");

      receiveStream(1'b0);
      reportTest("3 receive with syncs kept");

      receiveStream(1'b1);
      reportTest("4 receive with syncs stripped");

      // Overrun with RXIE and RXEN set
      writeReg(`dupADDR_RXCSR, 16'h0000, 1'b1, 1'b1);
      writeReg(`dupADDR_RXCSR, 16'h0050, 1'b1, 1'b1);
      sendByte(`dupSYNC_CHAR);
      waitRxDone(csr);
      @(negedge clk);
      checkBit("rxIntr", rxIntr, 1'b1);
      data = 8'($random(seed));
      sendByte(data);
      // Fixed three stage latency plus one
      waitCycles(4);
      readReg(`dupADDR_RXCSR, csr);
      checkBit("RXACT", csr[`dupRXCSR_RXACT], 1'b1);
      checkBit("RXDONE", csr[`dupRXCSR_RXDONE], 1'b1);
      readReg(`dupADDR_RXDBUF, dbuf);
      checkWord("RXDBUF", dbuf, {2'b11, 6'd0, data});
      @(negedge clk);
      checkBit("rxIntr", rxIntr, 1'b0);
      writeReg(`dupADDR_RXCSR, 16'h0040, 1'b1, 1'b1);
      readReg(`dupADDR_RXCSR, csr);
      checkBit("RXACT", csr[`dupRXCSR_RXACT], 1'b0);
      reportTest("5 overrun and interrupt");

      $display("checks %0d, errors %0d", checkCount, errCount);
      if (errCount == 0)
      begin
         $display("TESTBENCH PASSED");
      end
      else
      begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

   // Watchdog on the whole run
   initial
   begin
      cycleCount = 0;
      while (cycleCount < timeoutCycles)
      begin
         @(posedge clk);
         cycleCount++;
      end
      $display("run stopped after %0d cycles without finishing", timeoutCycles);
      $display("TESTBENCH FAILED");
      $finish;
   end

endmodule

// ==== vlog.f ====
+incdir+.
dupPkg.sv
dupRxCharIf.sv
dupRxShifter.sv
dupRxSyncStrip.sv
dupRxBuffer.sv
dupRxCsr.sv
dupRxTop.sv
tbDupRx.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the DUP11 receiver testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module tbDupRx -o simDupRx
./obj_dir/simDupRx > sim.log 2>&1
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
   echo "simulation reported failure"
   exit 1
fi
grep -q "TESTBENCH PASSED" sim.log
